// File: design/dc_pkg.sv
`default_nettype none

package dc_pkg;

  // physical address width
  localparam int PADDR_W = 32;

  // load ports sharing the arrays
  localparam int READ_PORT_NUM = 3;

  // associativity
  localparam int DC_WAYS  = 4;
  localparam int DC_WAY_W = $clog2(DC_WAYS);

  // lines per way, single bank
  localparam int DC_WORDS = 16;
  localparam int DC_IDX_W = $clog2(DC_WORDS);

  // one line is 64 bits
  localparam int DC_DATA_W   = 64;
  localparam int DC_DATA_B_W = DC_DATA_W / 8;
  localparam int DC_OFS_W    = $clog2(DC_DATA_B_W);

  // address layout, msb first
  //   tag    [PADDR_W-1    : DC_TAG_LOW]
  //   index  [DC_TAG_LOW-1 : DC_OFS_W]
  //   offset [DC_OFS_W-1   : 0]
  localparam int DC_TAG_LOW = DC_OFS_W + DC_IDX_W;
  localparam int DC_TAG_W   = PADDR_W - DC_TAG_LOW;

endpackage

`default_nettype wire

// File: design/dc_read_arbiter.sv
`default_nettype none

module dc_read_arbiter (
  input  logic [dc_pkg::READ_PORT_NUM-1:0]                   i_rd_valid,
  input  logic [dc_pkg::READ_PORT_NUM-1:0]                   i_rd_h_pri,
  input  logic [dc_pkg::READ_PORT_NUM-1:0][dc_pkg::PADDR_W-1:0] i_rd_paddr,
  output logic [dc_pkg::READ_PORT_NUM-1:0]                   o_grant,
  output logic [dc_pkg::DC_IDX_W-1:0]                        o_sel_idx
);

  import dc_pkg::*;

  logic [READ_PORT_NUM-1:0] w_hp_req;
  logic [READ_PORT_NUM-1:0] w_hp_oh;
  logic [READ_PORT_NUM-1:0] w_norm_oh;

  assign w_hp_req = i_rd_valid & i_rd_h_pri;

  // isolate lowest set bit of each request vector
  assign w_hp_oh   = w_hp_req & (~w_hp_req + 1'b1);
  assign w_norm_oh = i_rd_valid & (~i_rd_valid + 1'b1);

  // high priority group wins when present
  assign o_grant = (|w_hp_oh) ? w_hp_oh : w_norm_oh;

  // index of the granted port, one-hot or-mux
  always_comb begin
    o_sel_idx = '0;
    for (int p = 0; p < READ_PORT_NUM; p++) begin
      if (o_grant[p]) begin
        o_sel_idx = o_sel_idx | i_rd_paddr[p][DC_TAG_LOW-1:DC_OFS_W];
      end
    end
  end

  always_comb begin
    a_grant_onehot0 : assert ($onehot0(o_grant))
      else $error("arbiter granted more than one port");
    a_grant_subset : assert ((o_grant & ~i_rd_valid) == '0)
      else $error("arbiter granted an idle port");
    a_grant_live : assert (!(|i_rd_valid) || (|o_grant))
      else $error("arbiter left valid requests ungranted");
  end

endmodule

`default_nettype wire

// File: design/dc_tag_array.sv
`default_nettype none

module dc_tag_array (
  input  logic                         i_clk,
  input  logic                         i_reset_n,
  input  logic                         i_wr,
  input  logic [dc_pkg::DC_IDX_W-1:0]  i_addr,
  input  logic [dc_pkg::DC_TAG_W-1:0]  i_tag,
  output logic [dc_pkg::DC_TAG_W-1:0]  o_tag,
  output logic                         o_tag_valid
);

  import dc_pkg::*;

  logic [DC_TAG_W-1:0] r_tag [DC_WORDS];
  logic [DC_WORDS-1:0] r_valid;

  // tag storage, written by the update port only
  always_ff @(posedge i_clk) begin
    if (i_wr) begin
      r_tag[i_addr] <= i_tag;
    end
  end

  // a line becomes valid once written and stays so
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= '0;
    end else if (i_wr) begin
      r_valid[i_addr] <= 1'b1;
    end
  end

  // registered read port, old contents on a same-cycle write
  always_ff @(posedge i_clk) begin
    o_tag <= r_tag[i_addr];
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_tag_valid <= 1'b0;
    end else begin
      o_tag_valid <= r_valid[i_addr];
    end
  end

endmodule

`default_nettype wire

// File: design/dc_data_array.sv
`default_nettype none

module dc_data_array (
  input  logic                           i_clk,
  input  logic                           i_wr,
  input  logic [dc_pkg::DC_IDX_W-1:0]    i_addr,
  input  logic [dc_pkg::DC_DATA_B_W-1:0] i_be,
  input  logic [dc_pkg::DC_DATA_W-1:0]   i_data,
  output logic [dc_pkg::DC_DATA_W-1:0]   o_data
);

  import dc_pkg::*;

  logic [DC_DATA_W-1:0] r_mem [DC_WORDS];

  // byte-enable write
  always_ff @(posedge i_clk) begin
    if (i_wr) begin
      for (int b = 0; b < DC_DATA_B_W; b++) begin
        if (i_be[b]) begin
          r_mem[i_addr][b*8 +: 8] <= i_data[b*8 +: 8];
        end
      end
    end
  end

  // line appears one cycle after the address
  always_ff @(posedge i_clk) begin
    o_data <= r_mem[i_addr];
  end

  // an update always carries at least one byte
  a_wr_has_be : assert property (@(posedge i_clk) i_wr |-> (|i_be))
    else $error("data array write with no byte enable");

endmodule

`default_nettype wire

// File: design/dc_replace_ctrl.sv
`default_nettype none

module dc_replace_ctrl (
  input  logic                                                 i_clk,
  input  logic                                                 i_reset_n,
  input  logic [dc_pkg::READ_PORT_NUM-1:0]                     i_adv,
  input  logic [dc_pkg::READ_PORT_NUM-1:0][dc_pkg::DC_IDX_W-1:0] i_adv_idx,
  output logic [dc_pkg::DC_WORDS-1:0][dc_pkg::DC_WAY_W-1:0]    o_victim
);

  import dc_pkg::*;

  logic [DC_WORDS-1:0] w_adv_any;

  // merge all ports missing at the same index into one step
  always_comb begin
    w_adv_any = '0;
    for (int p = 0; p < READ_PORT_NUM; p++) begin
      if (i_adv[p]) begin
        w_adv_any[i_adv_idx[p]] = 1'b1;
      end
    end
  end

  // one round-robin way counter per index, wraps at DC_WAYS
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_victim <= '0;
    end else begin
      for (int i = 0; i < DC_WORDS; i++) begin
        if (w_adv_any[i]) begin
          o_victim[i] <= o_victim[i] + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: design/dc_port_resp.sv
`default_nettype none

module dc_port_resp (
  input  logic                                              i_clk,
  input  logic                                              i_reset_n,
  input  logic                                              i_req_valid,
  input  logic                                              i_granted,
  input  logic [dc_pkg::PADDR_W-1:0]                        i_paddr,
  input  logic [dc_pkg::DC_IDX_W-1:0]                       i_sel_idx,
  input  logic                                              i_upd_busy,
  input  logic [dc_pkg::DC_WAYS-1:0][dc_pkg::DC_TAG_W-1:0]  i_way_tag,
  input  logic [dc_pkg::DC_WAYS-1:0]                        i_way_valid,
  input  logic [dc_pkg::DC_WAYS-1:0][dc_pkg::DC_DATA_W-1:0] i_way_data,
  input  logic [dc_pkg::DC_WORDS-1:0][dc_pkg::DC_WAY_W-1:0] i_victim,
  output logic                                              o_hit,
  output logic                                              o_miss,
  output logic                                              o_conflict,
  output logic [dc_pkg::DC_WAY_W-1:0]                       o_hit_way,
  output logic [dc_pkg::DC_DATA_W-1:0]                      o_data,
  output logic                                              o_replace_valid,
  output logic [dc_pkg::DC_WAY_W-1:0]                       o_replace_way,
  output logic [dc_pkg::PADDR_W-1:0]                        o_replace_paddr,
  output logic [dc_pkg::DC_DATA_W-1:0]                      o_replace_data,
  output logic                                              o_adv
);

  import dc_pkg::*;

  logic                r_s1_valid;
  logic                r_s1_served;
  logic                r_s1_upd_busy;
  logic [DC_TAG_W-1:0] r_s1_tag;
  logic [DC_IDX_W-1:0] r_s1_idx;

  logic [DC_WAYS-1:0]  w_tag_hit;
  logic                w_lookup;

  // stage 0 capture
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s1_valid    <= 1'b0;
      r_s1_served   <= 1'b0;
      r_s1_upd_busy <= 1'b0;
      r_s1_tag      <= '0;
      r_s1_idx      <= '0;
    end else begin
      r_s1_valid    <= i_req_valid;
      // winner, or a loser that shares the winner's line
      r_s1_served   <= i_granted | (i_paddr[DC_TAG_LOW-1:DC_OFS_W] == i_sel_idx);
      r_s1_upd_busy <= i_upd_busy;
      r_s1_tag      <= i_paddr[PADDR_W-1:DC_TAG_LOW];
      r_s1_idx      <= i_paddr[DC_TAG_LOW-1:DC_OFS_W];
    end
  end

  // stage 1 tag compare against every way
  always_comb begin
    for (int w = 0; w < DC_WAYS; w++) begin
      w_tag_hit[w] = i_way_valid[w] & (i_way_tag[w] == r_s1_tag);
    end
  end

  // hit way number and line, or-mux on the hit vector
  always_comb begin
    o_hit_way = '0;
    o_data    = '0;
    for (int w = 0; w < DC_WAYS; w++) begin
      if (w_tag_hit[w]) begin
        o_hit_way = o_hit_way | DC_WAY_W'(w);
        o_data    = o_data | i_way_data[w];
      end
    end
  end

  assign w_lookup   = r_s1_valid & r_s1_served & ~r_s1_upd_busy;
  assign o_hit      = w_lookup & (|w_tag_hit);
  assign o_miss     = w_lookup & ~(|w_tag_hit);
  assign o_conflict = r_s1_valid & (r_s1_upd_busy | ~r_s1_served);

  // victim line for this index
  assign o_replace_way   = i_victim[r_s1_idx];
  assign o_replace_valid = o_miss & i_way_valid[o_replace_way];
  assign o_replace_data  = i_way_data[o_replace_way];
  assign o_replace_paddr = {i_way_tag[o_replace_way], r_s1_idx, {DC_OFS_W{1'b0}}};

  assign o_adv = o_miss;

  a_resp_excl : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    $onehot0({o_hit, o_miss, o_conflict}))
    else $error("port response is not exclusive");

  a_single_way_hit : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_hit |-> $onehot(w_tag_hit))
    else $error("line present in more than one way");

endmodule

`default_nettype wire

// File: design/dc_array_top.sv
`default_nettype none

module dc_array_top (
  input  logic                                                    i_clk,
  input  logic                                                    i_reset_n,

  input  logic                                                    i_upd_valid,
  input  logic [dc_pkg::DC_WAY_W-1:0]                             i_upd_way,
  input  logic [dc_pkg::PADDR_W-1:0]                              i_upd_paddr,
  input  logic [dc_pkg::DC_DATA_B_W-1:0]                          i_upd_be,
  input  logic [dc_pkg::DC_DATA_W-1:0]                            i_upd_data,

  input  logic [dc_pkg::READ_PORT_NUM-1:0]                        i_rd_valid,
  input  logic [dc_pkg::READ_PORT_NUM-1:0]                        i_rd_h_pri,
  input  logic [dc_pkg::READ_PORT_NUM-1:0][dc_pkg::PADDR_W-1:0]   i_rd_paddr,

  output logic [dc_pkg::READ_PORT_NUM-1:0]                        o_rd_hit,
  output logic [dc_pkg::READ_PORT_NUM-1:0]                        o_rd_miss,
  output logic [dc_pkg::READ_PORT_NUM-1:0]                        o_rd_conflict,
  output logic [dc_pkg::READ_PORT_NUM-1:0][dc_pkg::DC_WAY_W-1:0]  o_rd_hit_way,
  output logic [dc_pkg::READ_PORT_NUM-1:0][dc_pkg::DC_DATA_W-1:0] o_rd_data,
  output logic [dc_pkg::READ_PORT_NUM-1:0]                        o_rd_replace_valid,
  output logic [dc_pkg::READ_PORT_NUM-1:0][dc_pkg::DC_WAY_W-1:0]  o_rd_replace_way,
  output logic [dc_pkg::READ_PORT_NUM-1:0][dc_pkg::PADDR_W-1:0]   o_rd_replace_paddr,
  output logic [dc_pkg::READ_PORT_NUM-1:0][dc_pkg::DC_DATA_W-1:0] o_rd_replace_data
);

  import dc_pkg::*;

  logic [READ_PORT_NUM-1:0]               w_grant;
  logic [DC_IDX_W-1:0]                    w_sel_idx;
  logic [DC_IDX_W-1:0]                    w_arr_idx;
  logic [DC_WAYS-1:0]                     w_way_wr;

  logic [DC_WAYS-1:0][DC_TAG_W-1:0]       w_way_tag;
  logic [DC_WAYS-1:0]                     w_way_valid;
  logic [DC_WAYS-1:0][DC_DATA_W-1:0]      w_way_data;

  logic [DC_WORDS-1:0][DC_WAY_W-1:0]      w_victim;
  logic [READ_PORT_NUM-1:0]               w_adv;
  logic [READ_PORT_NUM-1:0][DC_IDX_W-1:0] w_adv_idx;

  dc_read_arbiter u_read_arbiter (
    .i_rd_valid (i_rd_valid),
    .i_rd_h_pri (i_rd_h_pri),
    .i_rd_paddr (i_rd_paddr),
    .o_grant    (w_grant),
    .o_sel_idx  (w_sel_idx)
  );

  // the update port owns the arrays in its cycle
  assign w_arr_idx = i_upd_valid ? i_upd_paddr[DC_TAG_LOW-1:DC_OFS_W] : w_sel_idx;

  for (genvar w = 0; w < DC_WAYS; w++) begin : g_way
    assign w_way_wr[w] = i_upd_valid & (i_upd_way == DC_WAY_W'(w));

    dc_tag_array u_tag (
      .i_clk       (i_clk),
      .i_reset_n   (i_reset_n),
      .i_wr        (w_way_wr[w]),
      .i_addr      (w_arr_idx),
      .i_tag       (i_upd_paddr[PADDR_W-1:DC_TAG_LOW]),
      .o_tag       (w_way_tag[w]),
      .o_tag_valid (w_way_valid[w])
    );

    dc_data_array u_data (
      .i_clk  (i_clk),
      .i_wr   (w_way_wr[w]),
      .i_addr (w_arr_idx),
      .i_be   (i_upd_be),
      .i_data (i_upd_data),
      .o_data (w_way_data[w])
    );
  end

  dc_replace_ctrl u_replace_ctrl (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_adv     (w_adv),
    .i_adv_idx (w_adv_idx),
    .o_victim  (w_victim)
  );

  for (genvar p = 0; p < READ_PORT_NUM; p++) begin : g_port
    dc_port_resp u_port_resp (
      .i_clk           (i_clk),
      .i_reset_n       (i_reset_n),
      .i_req_valid     (i_rd_valid[p]),
      .i_granted       (w_grant[p]),
      .i_paddr         (i_rd_paddr[p]),
      .i_sel_idx       (w_sel_idx),
      .i_upd_busy      (i_upd_valid),
      .i_way_tag       (w_way_tag),
      .i_way_valid     (w_way_valid),
      .i_way_data      (w_way_data),
      .i_victim        (w_victim),
      .o_hit           (o_rd_hit[p]),
      .o_miss          (o_rd_miss[p]),
      .o_conflict      (o_rd_conflict[p]),
      .o_hit_way       (o_rd_hit_way[p]),
      .o_data          (o_rd_data[p]),
      .o_replace_valid (o_rd_replace_valid[p]),
      .o_replace_way   (o_rd_replace_way[p]),
      .o_replace_paddr (o_rd_replace_paddr[p]),
      .o_replace_data  (o_rd_replace_data[p]),
      .o_adv           (w_adv[p])
    );

    // victim address carries the stage 1 index of the port
    assign w_adv_idx[p] = o_rd_replace_paddr[p][DC_TAG_LOW-1:DC_OFS_W];
  end

endmodule

`default_nettype wire

// File: sim/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen (
  output logic o_clk,
  output logic o_reset_n
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_PERIOD = 20;

  initial begin
    o_clk = 1'b0;
    forever #HALF_PERIOD o_clk = ~o_clk;
  end

  // held low for two rising edges, released away from the edge
  initial begin
    o_reset_n = 1'b0;
    repeat (2) @(posedge o_clk);
    @(negedge o_clk);
    o_reset_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: sim/tb_dc_array.sv
`default_nettype none

module tb_dc_array;

  timeunit 1ns;
  timeprecision 100ps;

  import dc_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam logic [31:0] LFSR_MASK = 32'h8020_0003;
  localparam int N_FILL = 12;
  localparam int N_MERGE = 8;
  localparam int ARB_PATS = 6;
  localparam int N_UPD_RD = 4;
  localparam int N_VICT = 6;
  localparam int TOTAL_CYCLES = 3 + 5 + 3 * N_FILL + 3 * N_MERGE + 2 + ARB_PATS
                                + 2 * N_UPD_RD + DC_WAYS + N_VICT + 2;

  logic clk;
  logic reset_n;

  logic                                    upd_valid;
  logic [DC_WAY_W-1:0]                     upd_way;
  logic [PADDR_W-1:0]                      upd_paddr;
  logic [DC_DATA_B_W-1:0]                  upd_be;
  logic [DC_DATA_W-1:0]                    upd_data;
  logic [READ_PORT_NUM-1:0]                rd_valid;
  logic [READ_PORT_NUM-1:0]                rd_h_pri;
  logic [READ_PORT_NUM-1:0][PADDR_W-1:0]   rd_paddr;

  logic [READ_PORT_NUM-1:0]                rd_hit;
  logic [READ_PORT_NUM-1:0]                rd_miss;
  logic [READ_PORT_NUM-1:0]                rd_conflict;
  logic [READ_PORT_NUM-1:0][DC_WAY_W-1:0]  rd_hit_way;
  logic [READ_PORT_NUM-1:0][DC_DATA_W-1:0] rd_data;
  logic [READ_PORT_NUM-1:0]                rd_replace_valid;
  logic [READ_PORT_NUM-1:0][DC_WAY_W-1:0]  rd_replace_way;
  logic [READ_PORT_NUM-1:0][PADDR_W-1:0]   rd_replace_paddr;
  logic [READ_PORT_NUM-1:0][DC_DATA_W-1:0] rd_replace_data;

  // reference model of the arrays and victim counters
  logic [DC_TAG_W-1:0]  m_tag [DC_WAYS][DC_WORDS];
  logic                 m_valid [DC_WAYS][DC_WORDS];
  logic [DC_DATA_W-1:0] m_data [DC_WAYS][DC_WORDS];
  logic [DC_WAY_W-1:0]  m_ctr [DC_WORDS];

  logic [31:0] r_lfsr;
  string       g_test;
  int          g_test_errors;
  int          g_errors;
  int          g_tests_passed;
  int          g_tests_failed;

  tb_clk_gen u_clk_gen (
    .o_clk     (clk),
    .o_reset_n (reset_n)
  );

  dc_array_top i_dc_array_top (
    .i_clk              (clk),
    .i_reset_n          (reset_n),
    .i_upd_valid        (upd_valid),
    .i_upd_way          (upd_way),
    .i_upd_paddr        (upd_paddr),
    .i_upd_be           (upd_be),
    .i_upd_data         (upd_data),
    .i_rd_valid         (rd_valid),
    .i_rd_h_pri         (rd_h_pri),
    .i_rd_paddr         (rd_paddr),
    .o_rd_hit           (rd_hit),
    .o_rd_miss          (rd_miss),
    .o_rd_conflict      (rd_conflict),
    .o_rd_hit_way       (rd_hit_way),
    .o_rd_data          (rd_data),
    .o_rd_replace_valid (rd_replace_valid),
    .o_rd_replace_way   (rd_replace_way),
    .o_rd_replace_paddr (rd_replace_paddr),
    .o_rd_replace_data  (rd_replace_data)
  );

  // galois lfsr, one step per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], r_lfsr[0]};
      r_lfsr = r_lfsr[0] ? ((r_lfsr >> 1) ^ LFSR_MASK) : (r_lfsr >> 1);
    end
    return v;
  endfunction

  function automatic logic [PADDR_W-1:0] make_paddr(input logic [DC_TAG_W-1:0] tag,
                                                     input logic [DC_IDX_W-1:0] idx,
                                                     input logic [DC_OFS_W-1:0] ofs);
    return {tag, idx, ofs};
  endfunction

  // reuse the way already holding this tag so no line sits in two ways
  function automatic logic [DC_WAY_W-1:0] pick_way(input logic [PADDR_W-1:0] a);
    logic [DC_IDX_W-1:0] idx;
    logic [DC_WAY_W-1:0] w_sel;
    idx = a[DC_TAG_LOW-1:DC_OFS_W];
    w_sel = DC_WAY_W'(rand_bits(DC_WAY_W));
    for (int w = 0; w < DC_WAYS; w++) begin
      if (m_valid[w][idx] && m_tag[w][idx] == a[PADDR_W-1:DC_TAG_LOW]) begin
        w_sel = DC_WAY_W'(w);
      end
    end
    return w_sel;
  endfunction

  task automatic check_value(input string what, input logic [63:0] exp,
                             input logic [63:0] act);
    if (exp !== act) begin
      $display("Mismatch %s %s: expected %h, actual %h", g_test, what, exp, act);
      g_test_errors++;
      g_errors++;
    end
  endtask

  task automatic start_test(input string name);
    g_test = name;
    g_test_errors = 0;
  endtask

  task automatic finish_test();
    if (g_test_errors == 0) begin
      $display("test %s: passed", g_test);
      g_tests_passed++;
    end else begin
      $display("test %s: failed with %0d mismatches", g_test, g_test_errors);
      g_tests_failed++;
    end
  endtask

  task automatic drive_idle();
    upd_valid = 1'b0;
    upd_way   = '0;
    upd_paddr = '0;
    upd_be    = '0;
    upd_data  = '0;
    rd_valid  = '0;
    rd_h_pri  = '0;
    rd_paddr  = '0;
  endtask

  task automatic set_read(input int p, input logic hpri, input logic [PADDR_W-1:0] a);
    rd_valid[p] = 1'b1;
    rd_h_pri[p] = hpri;
    rd_paddr[p] = a;
  endtask

  task automatic set_update(input logic [DC_WAY_W-1:0] w, input logic [PADDR_W-1:0] a,
                            input logic [DC_DATA_B_W-1:0] be,
                            input logic [DC_DATA_W-1:0] d);
    upd_valid = 1'b1;
    upd_way   = w;
    upd_paddr = a;
    upd_be    = be;
    upd_data  = d;
  endtask

  // predict from the model, clock once, compare, then update the model
  task automatic step_and_check();
    int                       win;
    int                       hit_w;
    logic [DC_IDX_W-1:0]      idx [READ_PORT_NUM];
    logic [DC_TAG_W-1:0]      tag [READ_PORT_NUM];
    logic [READ_PORT_NUM-1:0] e_hit;
    logic [READ_PORT_NUM-1:0] e_miss;
    logic [READ_PORT_NUM-1:0] e_conf;
    logic [READ_PORT_NUM-1:0] e_rv;
    logic [DC_WAY_W-1:0]      e_way [READ_PORT_NUM];
    logic [DC_WAY_W-1:0]      e_vict [READ_PORT_NUM];
    logic [DC_DATA_W-1:0]     e_data [READ_PORT_NUM];
    logic [DC_DATA_W-1:0]     e_rdata [READ_PORT_NUM];
    logic [PADDR_W-1:0]       e_rpaddr [READ_PORT_NUM];
    logic [DC_WORDS-1:0]      adv;
    logic [DC_IDX_W-1:0]      u_idx;
    win = -1;
    for (int p = 0; p < READ_PORT_NUM; p++) begin
      idx[p] = rd_paddr[p][DC_TAG_LOW-1:DC_OFS_W];
      tag[p] = rd_paddr[p][PADDR_W-1:DC_TAG_LOW];
      if (rd_valid[p] && rd_h_pri[p] && win < 0) win = p;
    end
    for (int p = 0; p < READ_PORT_NUM; p++) begin
      if (rd_valid[p] && win < 0) win = p;
    end
    for (int p = 0; p < READ_PORT_NUM; p++) begin
      e_hit[p] = 1'b0;
      e_miss[p] = 1'b0;
      e_conf[p] = 1'b0;
      e_rv[p] = 1'b0;
      e_way[p] = '0;
      e_vict[p] = m_ctr[idx[p]];
      e_data[p] = '0;
      e_rdata[p] = '0;
      e_rpaddr[p] = '0;
      if (rd_valid[p]) begin
        if (upd_valid || (p != win && idx[p] != idx[win])) begin
          e_conf[p] = 1'b1;
        end else begin
          hit_w = -1;
          for (int w = 0; w < DC_WAYS; w++) begin
            if (m_valid[w][idx[p]] && m_tag[w][idx[p]] == tag[p]) hit_w = w;
          end
          if (hit_w >= 0) begin
            e_hit[p] = 1'b1;
            e_way[p] = DC_WAY_W'(hit_w);
            e_data[p] = m_data[hit_w][idx[p]];
          end else begin
            e_miss[p] = 1'b1;
            e_rv[p] = m_valid[e_vict[p]][idx[p]];
            e_rdata[p] = m_data[e_vict[p]][idx[p]];
            e_rpaddr[p] = {m_tag[e_vict[p]][idx[p]], idx[p], {DC_OFS_W{1'b0}}};
          end
        end
      end
    end

    @(negedge clk);

    for (int p = 0; p < READ_PORT_NUM; p++) begin
      check_value($sformatf("p%0d hit", p), 64'(e_hit[p]), 64'(rd_hit[p]));
      check_value($sformatf("p%0d miss", p), 64'(e_miss[p]), 64'(rd_miss[p]));
      check_value($sformatf("p%0d conflict", p), 64'(e_conf[p]), 64'(rd_conflict[p]));
      check_value($sformatf("p%0d replace_valid", p), 64'(e_rv[p]),
                  64'(rd_replace_valid[p]));
      if (e_hit[p]) begin
        check_value($sformatf("p%0d hit_way", p), 64'(e_way[p]), 64'(rd_hit_way[p]));
        check_value($sformatf("p%0d data", p), e_data[p], rd_data[p]);
      end
      if (e_miss[p]) begin
        check_value($sformatf("p%0d replace_way", p), 64'(e_vict[p]),
                    64'(rd_replace_way[p]));
      end
      if (e_rv[p]) begin
        check_value($sformatf("p%0d replace_paddr", p), 64'(e_rpaddr[p]),
                    64'(rd_replace_paddr[p]));
        check_value($sformatf("p%0d replace_data", p), e_rdata[p], rd_replace_data[p]);
      end
    end

    if (upd_valid) begin
      u_idx = upd_paddr[DC_TAG_LOW-1:DC_OFS_W];
      m_tag[upd_way][u_idx] = upd_paddr[PADDR_W-1:DC_TAG_LOW];
      m_valid[upd_way][u_idx] = 1'b1;
      for (int b = 0; b < DC_DATA_B_W; b++) begin
        if (upd_be[b]) m_data[upd_way][u_idx][b*8 +: 8] = upd_data[b*8 +: 8];
      end
    end
    // several misses at one index count as one step
    adv = '0;
    for (int p = 0; p < READ_PORT_NUM; p++) begin
      if (e_miss[p]) adv[idx[p]] = 1'b1;
    end
    for (int i = 0; i < DC_WORDS; i++) begin
      if (adv[i]) m_ctr[i] = m_ctr[i] + 1'b1;
    end
    drive_idle();
  endtask

  task automatic reset_miss_test();
    start_test("reset_miss");
    check_value("hit after reset", '0, 64'(rd_hit));
    check_value("miss after reset", '0, 64'(rd_miss));
    check_value("conflict after reset", '0, 64'(rd_conflict));
    check_value("replace_valid after reset", '0, 64'(rd_replace_valid));
    for (int i = 0; i < 4; i++) begin
      set_read(i % READ_PORT_NUM, 1'b0, PADDR_W'(rand_bits(PADDR_W)));
      step_and_check();
    end
    finish_test();
  endtask

  task automatic full_write_test();
    logic [PADDR_W-1:0] a;
    start_test("full_write");
    for (int i = 0; i < N_FILL; i++) begin
      a = PADDR_W'(rand_bits(PADDR_W));
      set_update(pick_way(a), a, '1, rand_bits(DC_DATA_W));
      step_and_check();
      set_read(i % READ_PORT_NUM, 1'b0, a);
      step_and_check();
      // same index, top tag bit flipped
      set_read((i + 1) % READ_PORT_NUM, 1'b0, a ^ (PADDR_W'(1) << (PADDR_W - 1)));
      step_and_check();
    end
    finish_test();
  endtask

  task automatic byte_merge_test();
    logic [PADDR_W-1:0]     a;
    logic [DC_WAY_W-1:0]    w;
    logic [DC_DATA_B_W-1:0] be;
    start_test("byte_merge");
    for (int i = 0; i < N_MERGE; i++) begin
      a = PADDR_W'(rand_bits(PADDR_W));
      w = pick_way(a);
      set_update(w, a, '1, rand_bits(DC_DATA_W));
      step_and_check();
      be = DC_DATA_B_W'(rand_bits(DC_DATA_B_W));
      if (be == '0) be = 1;
      set_update(w, a, be, rand_bits(DC_DATA_W));
      step_and_check();
      set_read(i % READ_PORT_NUM, rand_bits(1) != 0, a);
      step_and_check();
    end
    finish_test();
  endtask

  task automatic arbitration_test();
    logic [PADDR_W-1:0] la;
    logic [PADDR_W-1:0] lb;
    logic [2:0] pat_valid [ARB_PATS];
    logic [2:0] pat_hpri [ARB_PATS];
    logic [PADDR_W-1:0] a [READ_PORT_NUM];
    start_test("arbitration");
    pat_valid = '{3'b111, 3'b111, 3'b111, 3'b101, 3'b110, 3'b011};
    pat_hpri  = '{3'b000, 3'b010, 3'b100, 3'b000, 3'b110, 3'b001};
    la = make_paddr(DC_TAG_W'(rand_bits(DC_TAG_W)), 4'd5, '0);
    lb = make_paddr(DC_TAG_W'(rand_bits(DC_TAG_W)), 4'd9, '0);
    set_update(pick_way(la), la, '1, rand_bits(DC_DATA_W));
    step_and_check();
    set_update(pick_way(lb), lb, '1, rand_bits(DC_DATA_W));
    step_and_check();
    for (int k = 0; k < ARB_PATS; k++) begin
      a[0] = la | PADDR_W'(rand_bits(DC_OFS_W));
      a[1] = lb;
      a[2] = make_paddr(DC_TAG_W'(rand_bits(DC_TAG_W)), 4'd5, DC_OFS_W'(rand_bits(DC_OFS_W)));
      for (int p = 0; p < READ_PORT_NUM; p++) begin
        if (pat_valid[k][p]) set_read(p, pat_hpri[k][p], a[p]);
      end
      step_and_check();
    end
    finish_test();
  endtask

  task automatic update_conflict_test();
    logic [PADDR_W-1:0] a;
    start_test("update_conflict");
    for (int i = 0; i < N_UPD_RD; i++) begin
      a = PADDR_W'(rand_bits(PADDR_W));
      set_update(pick_way(a), a, '1, rand_bits(DC_DATA_W));
      set_read(0, 1'b0, PADDR_W'(rand_bits(PADDR_W)));
      set_read(1, 1'b1, a);
      set_read(2, 1'b0, PADDR_W'(rand_bits(PADDR_W)));
      step_and_check();
      set_read(i % READ_PORT_NUM, 1'b0, a);
      step_and_check();
    end
    finish_test();
  endtask

  task automatic replacement_test();
    logic [DC_IDX_W-1:0] x;
    start_test("replacement");
    x = DC_IDX_W'(rand_bits(DC_IDX_W));
    for (int w = 0; w < DC_WAYS; w++) begin
      set_update(DC_WAY_W'(w), make_paddr(DC_TAG_W'(rand_bits(DC_TAG_W)), x, '0), '1,
                 rand_bits(DC_DATA_W));
      step_and_check();
    end
    for (int i = 0; i < N_VICT; i++) begin
      set_read(i % READ_PORT_NUM, 1'b0, make_paddr(DC_TAG_W'(rand_bits(DC_TAG_W)), x, '0));
      step_and_check();
    end
    // two misses at one index, counter must move once
    set_read(0, 1'b0, make_paddr(DC_TAG_W'(rand_bits(DC_TAG_W)), x, '0));
    set_read(1, 1'b0, make_paddr(DC_TAG_W'(rand_bits(DC_TAG_W)), x, 3'd4));
    step_and_check();
    set_read(2, 1'b0, make_paddr(DC_TAG_W'(rand_bits(DC_TAG_W)), x, '0));
    step_and_check();
    finish_test();
  endtask

  initial begin : watchdog
    #(TOTAL_CYCLES * CLK_PERIOD * 4);
    $display("watchdog: the run timed out before all tests finished");
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    drive_idle();
    r_lfsr = 32'd24;
    g_errors = 0;
    g_tests_passed = 0;
    g_tests_failed = 0;
    for (int w = 0; w < DC_WAYS; w++) begin
      for (int i = 0; i < DC_WORDS; i++) begin
        m_tag[w][i] = '0;
        m_valid[w][i] = 1'b0;
        m_data[w][i] = '0;
      end
    end
    for (int i = 0; i < DC_WORDS; i++) begin
      m_ctr[i] = '0;
    end
    @(posedge reset_n);
    @(negedge clk);
    reset_miss_test();
    full_write_test();
    byte_merge_test();
    arbitration_test();
    update_conflict_test();
    replacement_test();
    $display("tests passed %0d, tests failed %0d, mismatches %0d",
             g_tests_passed, g_tests_failed, g_errors);
    if (g_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
design/dc_pkg.sv
design/dc_read_arbiter.sv
design/dc_tag_array.sv
design/dc_data_array.sv
design/dc_replace_ctrl.sv
design/dc_port_resp.sv
design/dc_array_top.sv
sim/tb_clk_gen.sv
sim/tb_dc_array.sv

// File: run_sim.sh
#!/bin/sh
# build the data cache array testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --timescale 1ns/100ps -Wno-fatal \
  --top-module tb_dc_array -f files.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_dc_array > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^SIMULATION PASSED$" "$LOG"; then
  exit 0
fi
exit 1
